// File: recovery_handler.sv
// Recovery handler RX top level with steering, receiver, converter and data queue
`timescale 1ns/1ps

module recovery_handler
  import recovery_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    recovery_en_i,

  // Controller byte port
  input  logic                    ctl_rx_wvalid_i,
  output logic                    ctl_rx_wready_o,
  input  logic [BYTE_W-1:0]       ctl_rx_wdata_i,
  input  logic                    ctl_rx_wflush_i,
  input  logic                    ctl_bus_start_i,
  input  logic                    ctl_bus_stop_i,

  // Software read port
  input  logic                    csr_rx_req_i,
  output logic                    csr_rx_ack_o,
  output logic [QUEUE_DATA_W-1:0] csr_rx_data_o,

  // Parsed recovery command
  output logic                    cmd_valid_o,
  output logic [BYTE_W-1:0]       cmd_code_o,
  output logic [CMD_LEN_W-1:0]    cmd_len_o,
  output logic                    cmd_error_o,

  output logic                    rx_queue_empty_o,
  output logic                    rx_queue_full_o
);

  logic                    payload_select;
  logic                    payload_last;
  logic                    conv_valid;
  logic                    conv_ready;
  logic [BYTE_W-1:0]       conv_data;
  logic                    conv_flush;
  logic                    rcv_byte;
  logic [BYTE_W-1:0]       rcv_data;
  logic                    queue_wvalid;
  logic                    queue_wready;
  logic [QUEUE_DATA_W-1:0] queue_wdata;

  rx_byte_steer xrx_byte_steer (
    .recovery_en_i    (recovery_en_i),
    .payload_select_i (payload_select),
    .payload_last_i   (payload_last),
    .ctl_rx_wvalid_i  (ctl_rx_wvalid_i),
    .ctl_rx_wready_o  (ctl_rx_wready_o),
    .ctl_rx_wdata_i   (ctl_rx_wdata_i),
    .ctl_rx_wflush_i  (ctl_rx_wflush_i),
    .conv_valid_o     (conv_valid),
    .conv_ready_i     (conv_ready),
    .conv_data_o      (conv_data),
    .conv_flush_o     (conv_flush),
    .rcv_byte_o       (rcv_byte),
    .rcv_data_o       (rcv_data)
  );

  recovery_receiver xrecovery_receiver (
    .clk_i,
    .reset_i,
    .recovery_en_i    (recovery_en_i),
    .byte_valid_i     (rcv_byte),
    .byte_i           (rcv_data),
    .bus_start_i      (ctl_bus_start_i),
    .bus_stop_i       (ctl_bus_stop_i),
    .payload_select_o (payload_select),
    .payload_last_o   (payload_last),
    .cmd_valid_o      (cmd_valid_o),
    .cmd_code_o       (cmd_code_o),
    .cmd_len_o        (cmd_len_o),
    .cmd_error_o      (cmd_error_o)
  );

  width_converter_8to32 xconv_8to32 (
    .clk_i,
    .reset_i,
    .sink_valid_i   (conv_valid),
    .sink_ready_o   (conv_ready),
    .sink_data_i    (conv_data),
    .sink_flush_i   (conv_flush),
    .source_valid_o (queue_wvalid),
    .source_ready_i (queue_wready),
    .source_data_o  (queue_wdata)
  );

  rx_data_queue xrx_data_queue (
    .clk_i,
    .reset_i,
    .wvalid_i   (queue_wvalid),
    .wready_o   (queue_wready),
    .wdata_i    (queue_wdata),
    .csr_req_i  (csr_rx_req_i),
    .csr_ack_o  (csr_rx_ack_o),
    .csr_data_o (csr_rx_data_o),
    .empty_o    (rx_queue_empty_o),
    .full_o     (rx_queue_full_o)
  );

endmodule

// File: recovery_pec.sv
// CRC-8 accumulator for the recovery packet error code
`timescale 1ns/1ps

module recovery_pec
  import recovery_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              clear_i,
  input  logic              valid_i,
  input  logic [BYTE_W-1:0] dat_i,
  output logic [BYTE_W-1:0] crc_o
);

  // MSB first, one whole byte per call
  function automatic logic [BYTE_W-1:0] crc8_byte(input logic [BYTE_W-1:0] crc,
                                                  input logic [BYTE_W-1:0] dat);
    logic [BYTE_W-1:0] c;
    c = crc ^ dat;
    for (int i = 0; i < BYTE_W; i++) begin
      c = c[BYTE_W-1] ? ((c << 1) ^ PEC_POLY) : (c << 1);
    end
    return c;
  endfunction

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      crc_o <= '0;
    end else if (valid_i) begin
      crc_o <= crc8_byte(crc_o, dat_i);
    end
  end

endmodule

// File: recovery_pkg.sv
// Shared widths, queue depth and PEC polynomial for the recovery RX path
package recovery_pkg;

  // Bus and queue word sizes
  localparam int unsigned BYTE_W         = 8;
  localparam int unsigned QUEUE_DATA_W   = 32;
  localparam int unsigned BYTES_PER_WORD = 4;
  localparam int unsigned BYTE_IDX_W     = 2;

  // RX data queue geometry
  localparam int unsigned RX_QUEUE_DEPTH = 8;
  localparam int unsigned RX_QUEUE_PTR_W = 3;

  // Recovery packet length field
  localparam int unsigned CMD_LEN_W = 16;

  // CRC-8 used for the packet error code, initial value zero
  localparam logic [BYTE_W-1:0] PEC_POLY = 8'h07;

endpackage

// File: recovery_receiver.sv
// Recovery write packet parser with PEC check and command report
`timescale 1ns/1ps

module recovery_receiver
  import recovery_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 recovery_en_i,

  input  logic                 byte_valid_i,
  input  logic [BYTE_W-1:0]    byte_i,
  input  logic                 bus_start_i,
  input  logic                 bus_stop_i,

  output logic                 payload_select_o,
  output logic                 payload_last_o,

  output logic                 cmd_valid_o,
  output logic [BYTE_W-1:0]    cmd_code_o,
  output logic [CMD_LEN_W-1:0] cmd_len_o,
  output logic                 cmd_error_o
);

  enum logic [2:0] {
    ST_IDLE,
    ST_CMD,
    ST_LEN_LO,
    ST_LEN_HI,
    ST_PAYLOAD,
    ST_PEC
  } state_q, state_d;

  logic [CMD_LEN_W-1:0] remain_q;
  logic [BYTE_W-1:0]    pec_crc;
  logic                 byte_ok;
  logic                 abort;
  logic                 pec_valid;
  logic                 pec_done;

  recovery_pec xrecovery_pec (
    .clk_i,
    .reset_i,
    .clear_i (bus_start_i),
    .valid_i (pec_valid),
    .dat_i   (byte_i),
    .crc_o   (pec_crc)
  );

  // Bus conditions take precedence over a byte in the same cycle
  assign byte_ok   = byte_valid_i && !bus_start_i && !bus_stop_i;
  assign abort     = bus_stop_i && state_q != ST_IDLE;
  assign pec_valid = byte_ok && state_q inside {ST_CMD, ST_LEN_LO, ST_LEN_HI, ST_PAYLOAD};
  assign pec_done  = byte_ok && state_q == ST_PEC;

  assign payload_select_o = state_q == ST_PAYLOAD;
  assign payload_last_o   = state_q == ST_PAYLOAD && remain_q == CMD_LEN_W'(1);

  always_comb begin
    state_d = state_q;
    if (!recovery_en_i || abort) begin
      state_d = ST_IDLE;
    end else if (bus_start_i) begin
      state_d = ST_CMD;
    end else if (byte_ok) begin
      case (state_q)
        ST_CMD:     state_d = ST_LEN_LO;
        ST_LEN_LO:  state_d = ST_LEN_HI;
        // Zero length skips the payload
        ST_LEN_HI:  state_d = ({byte_i, cmd_len_o[BYTE_W-1:0]} == '0) ? ST_PEC : ST_PAYLOAD;
        ST_PAYLOAD: state_d = payload_last_o ? ST_PEC : ST_PAYLOAD;
        ST_PEC:     state_d = ST_IDLE;
        default:    state_d = ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= ST_IDLE;
      cmd_valid_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      cmd_valid_o <= pec_done || abort;
    end
  end

  // Command fields, length is little-endian on the bus
  always_ff @(posedge clk_i) begin
    if (pec_done || abort) begin
      cmd_error_o <= abort || (byte_i != pec_crc);
    end
    if (byte_ok) begin
      case (state_q)
        ST_CMD:    cmd_code_o <= byte_i;
        ST_LEN_LO: cmd_len_o[BYTE_W-1:0] <= byte_i;
        ST_LEN_HI: begin
          cmd_len_o[CMD_LEN_W-1:BYTE_W] <= byte_i;
          remain_q <= {byte_i, cmd_len_o[BYTE_W-1:0]};
        end
        ST_PAYLOAD: remain_q <= remain_q - 1'b1;
        default:    remain_q <= remain_q;
      endcase
    end
  end

endmodule

// File: recovery_tests.txt
# Columns: kind a b c, all hex. M mode | S start | P stop | B byte flush | R first count
# W expected word | C code len error | F queue full and ready low. Unused fields are 0
# Normal mode, two full words
M 0 0 0
R 01 08 0
W 04030201 0 0
W 08070605 0 0
# Flush with the sixth byte
R a1 05 0
B a6 1 0
W a4a3a2a1 0 0
W 0000a6a5 0 0
# Recovery packet, command 01, length 4, PEC 7a
M 1 0 0
S 0 0 0
B 01 0 0
B 04 0 0
B 00 0 0
R 11 04 0
B 7a 0 0
P 0 0 0
C 01 0004 0
W 14131211 0 0
# Same packet with a corrupted PEC
S 0 0 0
B 01 0 0
B 04 0 0
B 00 0 0
R 11 04 0
B 7b 0 0
P 0 0 0
C 01 0004 1
W 14131211 0 0
# Stop inside the length field, then a zero-length packet with PEC d6
S 0 0 0
B 01 0 0
B 04 0 0
P 0 0 0
C 01 0004 1
S 0 0 0
B 02 0 0
B 00 0 0
B 00 0 0
B d6 0 0
P 0 0 0
C 02 0000 0
# Nine words without reads
M 0 0 0
R 01 24 0
F 0 0 0
W 04030201 0 0
W 08070605 0 0
W 0c0b0a09 0 0
W 100f0e0d 0 0
W 14131211 0 0
W 18171615 0 0
W 1c1b1a19 0 0
W 201f1e1d 0 0
W 24232221 0 0

// File: run.sh
#!/bin/sh
# Builds and runs the recovery handler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_recovery_handler \
  -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
fi

if grep -q "^RESULT: PASS$" sim.log; then
  exit 0
fi
exit 1

// File: rx_byte_steer.sv
// Byte steering between the RX queue path and the recovery receiver
`timescale 1ns/1ps

module rx_byte_steer
  import recovery_pkg::*;
(
  input  logic              recovery_en_i,
  input  logic              payload_select_i,
  input  logic              payload_last_i,

  input  logic              ctl_rx_wvalid_i,
  output logic              ctl_rx_wready_o,
  input  logic [BYTE_W-1:0] ctl_rx_wdata_i,
  input  logic              ctl_rx_wflush_i,

  output logic              conv_valid_o,
  input  logic              conv_ready_i,
  output logic [BYTE_W-1:0] conv_data_o,
  output logic              conv_flush_o,

  output logic              rcv_byte_o,
  output logic [BYTE_W-1:0] rcv_data_o
);

  logic to_queue;

  // Payload bytes of a recovery packet still land in the data queue
  assign to_queue = !recovery_en_i || payload_select_i;

  assign conv_valid_o = ctl_rx_wvalid_i && to_queue;
  assign conv_data_o  = ctl_rx_wdata_i;
  assign conv_flush_o = recovery_en_i ? payload_last_i : ctl_rx_wflush_i;

  // Receiver never stalls, the queue path may
  assign ctl_rx_wready_o = to_queue ? conv_ready_i : 1'b1;

  // Receiver sees every accepted byte, for the PEC
  assign rcv_byte_o = recovery_en_i && ctl_rx_wvalid_i && ctl_rx_wready_o;
  assign rcv_data_o = ctl_rx_wdata_i;

endmodule

// File: rx_data_queue.sv
// RX data word FIFO with valid/ready write side and req/ack CSR read side
`timescale 1ns/1ps

module rx_data_queue
  import recovery_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,

  input  logic                    wvalid_i,
  output logic                    wready_o,
  input  logic [QUEUE_DATA_W-1:0] wdata_i,

  input  logic                    csr_req_i,
  output logic                    csr_ack_o,
  output logic [QUEUE_DATA_W-1:0] csr_data_o,

  output logic                    empty_o,
  output logic                    full_o
);

  logic [QUEUE_DATA_W-1:0]   mem_q [RX_QUEUE_DEPTH];
  logic [RX_QUEUE_PTR_W-1:0] wptr_q;
  logic [RX_QUEUE_PTR_W-1:0] rptr_q;
  logic [RX_QUEUE_PTR_W:0]   count_q;
  logic                      push;
  logic                      pop;

  assign empty_o  = count_q == '0;
  assign full_o   = count_q == (RX_QUEUE_PTR_W + 1)'(RX_QUEUE_DEPTH);
  assign wready_o = !full_o;

  assign push = wvalid_i && !full_o;
  // One pop per request, the ack cycle itself does not count
  assign pop  = csr_req_i && !empty_o && !csr_ack_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_q    <= '0;
      rptr_q    <= '0;
      count_q   <= '0;
      csr_ack_o <= 1'b0;
    end else begin
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      csr_ack_o <= pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
    if (pop) begin
      csr_data_o <= mem_q[rptr_q];
    end
  end

endmodule

// File: src.f
recovery_pkg.sv
rx_byte_steer.sv
width_converter_8to32.sv
rx_data_queue.sv
recovery_pec.sv
recovery_receiver.sv
recovery_handler.sv
tb_recovery_handler.sv

// File: tb_recovery_handler.sv
// Testbench for the recovery handler RX path, driven by records from a test file
`timescale 1ns/1ps

module tb_recovery_handler
  import recovery_pkg::*;
();

  localparam int MAX_RECORDS      = 256;
  localparam int CYCLES_PER_ENTRY = 50;

  logic                    clk;
  logic                    reset;
  logic                    recovery_en;
  logic                    ctl_rx_wvalid;
  logic                    ctl_rx_wready;
  logic [BYTE_W-1:0]       ctl_rx_wdata;
  logic                    ctl_rx_wflush;
  logic                    ctl_bus_start;
  logic                    ctl_bus_stop;
  logic                    csr_rx_req;
  logic                    csr_rx_ack;
  logic [QUEUE_DATA_W-1:0] csr_rx_data;
  logic                    cmd_valid;
  logic [BYTE_W-1:0]       cmd_code;
  logic [CMD_LEN_W-1:0]    cmd_len;
  logic                    cmd_error;
  logic                    rx_queue_empty;
  logic                    rx_queue_full;

  // One kind letter and three hex fields per record
  logic [7:0]  rec_kind [MAX_RECORDS];
  logic [31:0] rec_a [MAX_RECORDS];
  logic [31:0] rec_b [MAX_RECORDS];
  logic [31:0] rec_c [MAX_RECORDS];
  int          n_records = 0;
  logic        records_loaded = 1'b0;
  integer      seed;

  // Reports as {error, length, code}
  logic [CMD_LEN_W+BYTE_W:0] cmd_seen_q [$];

  recovery_handler i_recovery_handler (
    .clk_i            (clk),
    .reset_i          (reset),
    .recovery_en_i    (recovery_en),
    .ctl_rx_wvalid_i  (ctl_rx_wvalid),
    .ctl_rx_wready_o  (ctl_rx_wready),
    .ctl_rx_wdata_i   (ctl_rx_wdata),
    .ctl_rx_wflush_i  (ctl_rx_wflush),
    .ctl_bus_start_i  (ctl_bus_start),
    .ctl_bus_stop_i   (ctl_bus_stop),
    .csr_rx_req_i     (csr_rx_req),
    .csr_rx_ack_o     (csr_rx_ack),
    .csr_rx_data_o    (csr_rx_data),
    .cmd_valid_o      (cmd_valid),
    .cmd_code_o       (cmd_code),
    .cmd_len_o        (cmd_len),
    .cmd_error_o      (cmd_error),
    .rx_queue_empty_o (rx_queue_empty),
    .rx_queue_full_o  (rx_queue_full)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Command pulses are one cycle wide, so capture them as they come
  always @(posedge clk) begin
    if (!reset && cmd_valid) begin
      cmd_seen_q.push_back({cmd_error, cmd_len, cmd_code});
    end
  end

  initial begin
    wait (records_loaded);
    repeat (n_records * CYCLES_PER_ENTRY) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d clock cycles",
             n_records * CYCLES_PER_ENTRY);
    $display("RESULT: FAIL");
    $fatal(1, "Watchdog expired");
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
      $display("RESULT: FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic stop_on_file_error(input string what);
    $display("Test file problem: %s", what);
    $display("RESULT: FAIL");
    $fatal(1, "Bad test file");
  endtask

  task automatic load_records();
    integer           fd;
    integer           status;
    logic [7:0]       kind;
    logic [8*160-1:0] line_buf;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      c;
    fd = $fopen("recovery_tests.txt", "r");
    if (fd == 0) begin
      stop_on_file_error("recovery_tests.txt cannot be opened for reading");
    end
    status = $fscanf(fd, " %c", kind);
    while (status == 1) begin
      if (kind == "#") begin
        status = $fgets(line_buf, fd);
      end else begin
        status = $fscanf(fd, "%h %h %h", a, b, c);
        if (status != 3 || n_records == MAX_RECORDS) begin
          stop_on_file_error("a record is malformed or there are too many records");
        end
        rec_kind[n_records] = kind;
        rec_a[n_records]    = a;
        rec_b[n_records]    = b;
        rec_c[n_records]    = c;
        n_records++;
      end
      status = $fscanf(fd, " %c", kind);
    end
    $fclose(fd);
    if (n_records == 0) begin
      stop_on_file_error("recovery_tests.txt holds no records");
    end
  endtask

  // Entered and left 2 ns after a rising edge
  task automatic send_byte(input logic [7:0] data, input logic flush);
    integer gap;
    ctl_rx_wvalid = 1'b1;
    ctl_rx_wdata  = data;
    ctl_rx_wflush = flush;
    #1;
    while (!ctl_rx_wready) begin
      @(posedge clk);
      #3;
    end
    @(posedge clk);
    #2;
    ctl_rx_wvalid = 1'b0;
    ctl_rx_wflush = 1'b0;
    gap = $unsigned($random(seed)) % 3;
    repeat (gap) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic pulse_bus(input logic is_stop);
    ctl_bus_start = !is_stop;
    ctl_bus_stop  = is_stop;
    @(posedge clk);
    #2;
    ctl_bus_start = 1'b0;
    ctl_bus_stop  = 1'b0;
  endtask

  task automatic read_word(input logic [31:0] expected);
    logic [31:0] got;
    csr_rx_req = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!csr_rx_ack);
    got = csr_rx_data;
    #1;
    csr_rx_req = 1'b0;
    check_value("csr_rx_data_o", got, expected);
  endtask

  task automatic expect_command(input logic [7:0] code, input logic [15:0] len,
                                input logic err);
    logic [CMD_LEN_W+BYTE_W:0] seen;
    while (cmd_seen_q.size() == 0) begin
      @(posedge clk);
      #2;
    end
    seen = cmd_seen_q.pop_front();
    check_value("cmd_error_o", 32'(seen[CMD_LEN_W+BYTE_W]), 32'(err));
    // Code and length of a failed packet are undefined
    if (!err) begin
      check_value("cmd_code_o", 32'(seen[BYTE_W-1:0]), 32'(code));
      check_value("cmd_len_o", 32'(seen[CMD_LEN_W+BYTE_W-1:BYTE_W]), 32'(len));
    end
  endtask

  task automatic run_record(input int idx);
    logic [31:0] a;
    logic [31:0] b;
    int          i;
    a = rec_a[idx];
    b = rec_b[idx];
    case (rec_kind[idx])
      "M": begin
        recovery_en = a[0];
        @(posedge clk);
        #2;
      end
      "S": pulse_bus(1'b0);
      "P": pulse_bus(1'b1);
      "B": send_byte(a[7:0], b[0]);
      "R": begin
        for (i = 0; i < b; i++) begin
          send_byte(a[7:0] + i[7:0], 1'b0);
        end
      end
      "W": read_word(a);
      "C": expect_command(a[7:0], b[15:0], rec_c[idx][0]);
      "F": begin
        @(posedge clk);
        #2;
        check_value("rx_queue_full_o", 32'(rx_queue_full), 32'd1);
        check_value("rx_queue_empty_o", 32'(rx_queue_empty), 32'd0);
        check_value("ctl_rx_wready_o", 32'(ctl_rx_wready), 32'd0);
      end
      default: stop_on_file_error("a record has an unknown kind letter");
    endcase
  endtask

  initial begin
    int idx;
    reset         = 1'b1;
    recovery_en   = 1'b0;
    ctl_rx_wvalid = 1'b0;
    ctl_rx_wdata  = '0;
    ctl_rx_wflush = 1'b0;
    ctl_bus_start = 1'b0;
    ctl_bus_stop  = 1'b0;
    csr_rx_req    = 1'b0;
    seed          = 32'h8f17_3716;
    load_records();
    records_loaded = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    // Idle state left by reset
    check_value("rx_queue_empty_o", 32'(rx_queue_empty), 32'd1);
    check_value("rx_queue_full_o", 32'(rx_queue_full), 32'd0);
    check_value("ctl_rx_wready_o", 32'(ctl_rx_wready), 32'd1);
    check_value("csr_rx_ack_o", 32'(csr_rx_ack), 32'd0);
    check_value("cmd_valid_o", 32'(cmd_valid), 32'd0);
    for (idx = 0; idx < n_records; idx++) begin
      run_record(idx);
    end
    if (cmd_seen_q.size() != 0) begin
      $display("A command report arrived that no record expected");
      $display("RESULT: FAIL");
      $fatal(1, "Unexpected command report");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: width_converter_8to32.sv
// Byte to 32-bit word packer with flush of partial words
`timescale 1ns/1ps

module width_converter_8to32
  import recovery_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,

  input  logic                    sink_valid_i,
  output logic                    sink_ready_o,
  input  logic [BYTE_W-1:0]       sink_data_i,
  input  logic                    sink_flush_i,

  output logic                    source_valid_o,
  input  logic                    source_ready_i,
  output logic [QUEUE_DATA_W-1:0] source_data_o
);

  logic [BYTE_IDX_W-1:0]   byte_idx_q;
  logic [QUEUE_DATA_W-1:0] acc_q;
  logic [QUEUE_DATA_W-1:0] acc_next;
  logic                    accept;
  logic                    emit;

  // Held word blocks new bytes until the queue takes it
  assign sink_ready_o = !source_valid_o || source_ready_i;
  assign accept       = sink_valid_i && sink_ready_o;
  assign emit         = accept &&
                        (sink_flush_i || byte_idx_q == BYTE_IDX_W'(BYTES_PER_WORD - 1));

  // Little-endian lane placement
  always_comb begin
    acc_next = acc_q;
    acc_next[byte_idx_q*BYTE_W +: BYTE_W] = sink_data_i;
  end

  // Accumulator is cleared per word so flushed words carry zero upper bytes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      byte_idx_q     <= '0;
      acc_q          <= '0;
      source_valid_o <= 1'b0;
    end else begin
      if (source_valid_o && source_ready_i) begin
        source_valid_o <= 1'b0;
      end
      if (emit) begin
        source_valid_o <= 1'b1;
        byte_idx_q     <= '0;
        acc_q          <= '0;
      end else if (accept) begin
        byte_idx_q <= byte_idx_q + 1'b1;
        acc_q      <= acc_next;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (emit) begin
      source_data_o <= acc_next;
    end
  end

endmodule
